//--- common/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // data word, also used for byte addresses
    typedef logic [31:0] word_t;

    // register file write address
    typedef logic [4:0] reg_addr_t;

    // memory op code from execute
    typedef logic [4:0] mem_op_t;

    // access size code
    typedef logic [1:0] mem_size_t;

    // one write enable per byte lane
    typedef logic [3:0] byte_en_t;

    // field positions inside mem_op_t
    // bit 4 marks a load or store
    localparam int MEM_OP_EN_BIT       = 4;
    // size field, same encoding as mem_size_t
    localparam int MEM_OP_SIZE_HI      = 3;
    localparam int MEM_OP_SIZE_LO      = 2;
    // set for stores, clear for loads
    localparam int MEM_OP_WRITE_BIT    = 1;
    // set means zero-extend on loads
    localparam int MEM_OP_UNSIGNED_BIT = 0;

    // access size codes
    // code 2 is unused and falls back to a word access
    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd3;

    // data RAM geometry
    localparam int RAM_DEPTH_WORDS = 256;
    // word index comes from address bits 9..2
    // upper address bits are dropped, so the RAM aliases
    localparam int RAM_INDEX_W     = 8;

    // controller sequence, one access at a time
    // idle waits for a request
    // access enables the RAM
    // done returns the ack pulse
    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ACCESS,
        CTRL_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- mem_access/mem_access.sv
`default_nettype none

module mem_access import mem_pkg::*; (
    input  wire        clk,
    input  wire        rst,

    // write-back fields and result from execute
    input  wire        wb_en_i,
    input  reg_addr_t  wb_addr_i,
    input  word_t      alu_result_i,
    input  word_t      store_data_i,
    input  mem_op_t    mem_op_i,

    // write-back fields towards the register file
    output logic       wb_en_o,
    output reg_addr_t  wb_addr_o,
    output word_t      wb_data_o,

    // freezes fetch, decode and execute
    output logic       stall_o,

    // request side of the controller handshake
    output logic       mem_req_o,
    output logic       mem_write_o,
    output mem_size_t  mem_size_o,
    output word_t      mem_addr_o,
    output word_t      mem_wdata_o,
    input  wire        mem_ack_i,
    input  word_t      mem_rdata_i
);

    logic      mem_en;
    logic      is_write;
    logic      is_unsigned;
    mem_size_t op_size;

    // raw data arrives right-aligned from the controller
    function automatic word_t extend_load(input word_t raw, input mem_size_t size,
                                          input logic zero_ext);
        word_t result;
        case (size)
            SIZE_BYTE: begin
                if (zero_ext) begin
                    result = {24'h0, raw[7:0]};
                end else begin
                    result = {{24{raw[7]}}, raw[7:0]};
                end
            end
            SIZE_HALF: begin
                if (zero_ext) begin
                    result = {16'h0, raw[15:0]};
                end else begin
                    result = {{16{raw[15]}}, raw[15:0]};
                end
            end
            // full word, no extension needed
            default: result = raw;
        endcase
        return result;
    endfunction

    // decode the op fields
    assign mem_en      = mem_op_i[MEM_OP_EN_BIT];
    assign is_write    = mem_op_i[MEM_OP_WRITE_BIT];
    assign is_unsigned = mem_op_i[MEM_OP_UNSIGNED_BIT];
    assign op_size     = mem_op_i[MEM_OP_SIZE_HI:MEM_OP_SIZE_LO];

    always_comb begin
        wb_en_o     = 1'b0;
        wb_addr_o   = '0;
        wb_data_o   = '0;
        stall_o     = 1'b0;
        mem_req_o   = 1'b0;
        mem_write_o = 1'b0;
        mem_size_o  = '0;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        if (!rst) begin
            // enable and address are never touched here
            wb_en_o   = wb_en_i;
            wb_addr_o = wb_addr_i;
            // default result, also what a store writes back
            wb_data_o = alu_result_i;
            if (mem_en) begin
                // request fields follow the frozen inputs
                mem_write_o = is_write;
                mem_size_o  = op_size;
                mem_addr_o  = alu_result_i;
                mem_wdata_o = store_data_i;
                if (mem_ack_i) begin
                    // ack cycle: drop request, let upstream advance
                    if (!is_write) begin
                        wb_data_o = extend_load(mem_rdata_i, op_size, is_unsigned);
                    end
                end else begin
                    // hold request and freeze pipe until ack
                    mem_req_o = 1'b1;
                    stall_o   = 1'b1;
                end
            end
        end
    end

    // request must not change or vanish before the ack
    property p_req_stable;
        @(posedge clk) disable iff (rst)
        (mem_req_o && !mem_ack_i) |=>
            (mem_req_o || mem_ack_i) &&
            $stable(mem_write_o) && $stable(mem_size_o) &&
            $stable(mem_addr_o) && $stable(mem_wdata_o);
    endproperty
    a_req_stable: assert property (p_req_stable)
        else $error("mem_access: request changed before ack");

    // a stall without a memory op would hang the pipe
    property p_stall_needs_mem_op;
        @(posedge clk) disable iff (rst)
        stall_o |-> mem_en;
    endproperty
    a_stall_needs_mem_op: assert property (p_stall_needs_mem_op)
        else $error("mem_access: stall with no memory op");

endmodule

`default_nettype wire

//--- mem_ctrl/data_ram.sv
`default_nettype none

module data_ram import mem_pkg::*; (
    input  wire                     clk,

    // single port shared by reads and writes
    input  wire                     en_i,
    input  byte_en_t                we_i,
    input  wire [RAM_INDEX_W-1:0]   index_i,
    input  word_t                   wdata_i,
    output word_t                   rdata_o
);

    // word storage
    // no reset on contents
    word_t mem [RAM_DEPTH_WORDS];

    // per-lane write
    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (we_i[b]) begin
                    mem[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // registered read
    // old word comes out on a write cycle
    // data valid the cycle after en_i
    always_ff @(posedge clk) begin
        if (en_i) begin
            rdata_o <= mem[index_i];
        end
    end

endmodule

`default_nettype wire

//--- mem_ctrl/mem_ctrl.sv
`default_nettype none

module mem_ctrl import mem_pkg::*; (
    input  wire        clk,
    input  wire        rst,

    // request from the memory stage
    input  wire        mem_req_i,
    input  wire        mem_write_i,
    input  mem_size_t  mem_size_i,
    input  word_t      mem_addr_i,
    input  word_t      mem_wdata_i,
    output logic       mem_ack_o,
    output word_t      mem_rdata_o,

    // data RAM port
    output logic                    ram_en_o,
    output byte_en_t                ram_we_o,
    output logic [RAM_INDEX_W-1:0]  ram_index_o,
    output word_t                   ram_wdata_o,
    input  word_t                   ram_rdata_i
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // captured when a request is taken in idle
    logic [1:0]  offset_q;
    mem_size_t   size_q;

    byte_en_t    lane_en;
    word_t       load_shifted;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE: begin
                if (mem_req_i) begin
                    state_d = CTRL_ACCESS;
                end
            end
            CTRL_ACCESS: state_d = CTRL_DONE;
            // done always goes back to idle, even with a new request pending
            CTRL_DONE:   state_d = CTRL_IDLE;
            default:     state_d = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // offset and size kept for the load path
    always_ff @(posedge clk) begin
        if (state_q == CTRL_IDLE && mem_req_i) begin
            offset_q <= mem_addr_i[1:0];
            size_q   <= mem_size_i;
        end
    end

    // byte lanes touched by the access
    always_comb begin
        case (size_q)
            SIZE_BYTE: lane_en = byte_en_t'(4'b0001 << offset_q);
            SIZE_HALF: lane_en = byte_en_t'(4'b0011 << offset_q);
            default:   lane_en = 4'b1111;
        endcase
    end

    // replicate store data so every candidate lane carries it
    always_comb begin
        case (size_q)
            SIZE_BYTE: ram_wdata_o = {4{mem_wdata_i[7:0]}};
            SIZE_HALF: ram_wdata_o = {2{mem_wdata_i[15:0]}};
            default:   ram_wdata_o = mem_wdata_i;
        endcase
    end

    // RAM only enabled in the access cycle
    // request fields are still held by the stage here
    assign ram_en_o    = (state_q == CTRL_ACCESS);
    assign ram_we_o    = (ram_en_o && mem_write_i) ? lane_en : '0;
    assign ram_index_o = mem_addr_i[RAM_INDEX_W+1:2];

    // read word is back in done, move addressed bytes down to bit 0
    assign load_shifted = ram_rdata_i >> {offset_q, 3'b000};

    always_comb begin
        case (size_q)
            SIZE_BYTE: mem_rdata_o = {24'h0, load_shifted[7:0]};
            SIZE_HALF: mem_rdata_o = {16'h0, load_shifted[15:0]};
            default:   mem_rdata_o = load_shifted;
        endcase
    end

    // one-cycle ack pulse
    assign mem_ack_o = (state_q == CTRL_DONE);

    // stage must only send naturally aligned accesses
    property p_aligned;
        @(posedge clk) disable iff (rst)
        (state_q == CTRL_IDLE && mem_req_i) |->
            !(mem_size_i == SIZE_HALF && mem_addr_i[0]) &&
            !(mem_size_i == SIZE_WORD && mem_addr_i[1:0] != 2'b00);
    endproperty
    a_aligned: assert property (p_aligned)
        else $error("mem_ctrl: misaligned access at %h", mem_addr_i);

    // ack is a pulse, the stage drops the request on it
    property p_ack_pulse;
        @(posedge clk) disable iff (rst)
        mem_ack_o |=> !mem_ack_o;
    endproperty
    a_ack_pulse: assert property (p_ack_pulse)
        else $error("mem_ctrl: ack held for two cycles");

endmodule

`default_nettype wire

//--- rtl/mem_subsys_top.sv
`default_nettype none

module mem_subsys_top import mem_pkg::*; (
    input  wire        clk,
    input  wire        rst,

    // from execute
    input  wire        wb_en_i,
    input  reg_addr_t  wb_addr_i,
    input  word_t      alu_result_i,
    input  word_t      store_data_i,
    input  mem_op_t    mem_op_i,

    // to write-back and upstream
    output logic       wb_en_o,
    output reg_addr_t  wb_addr_o,
    output word_t      wb_data_o,
    output logic       stall_o
);

    // stage to controller
    logic       mem_req;
    logic       mem_write;
    mem_size_t  mem_size;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic       mem_ack;
    word_t      mem_rdata;

    // controller to RAM
    logic                    ram_en;
    byte_en_t                ram_we;
    logic [RAM_INDEX_W-1:0]  ram_index;
    word_t                   ram_wdata;
    word_t                   ram_rdata;

    mem_access u_mem_access (
        .clk          (clk),
        .rst          (rst),
        .wb_en_i      (wb_en_i),
        .wb_addr_i    (wb_addr_i),
        .alu_result_i (alu_result_i),
        .store_data_i (store_data_i),
        .mem_op_i     (mem_op_i),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .stall_o      (stall_o),
        .mem_req_o    (mem_req),
        .mem_write_o  (mem_write),
        .mem_size_o   (mem_size),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_ack_i    (mem_ack),
        .mem_rdata_i  (mem_rdata)
    );

    mem_ctrl u_mem_ctrl (
        .clk         (clk),
        .rst         (rst),
        .mem_req_i   (mem_req),
        .mem_write_i (mem_write),
        .mem_size_i  (mem_size),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_ack_o   (mem_ack),
        .mem_rdata_o (mem_rdata),
        .ram_en_o    (ram_en),
        .ram_we_o    (ram_we),
        .ram_index_o (ram_index),
        .ram_wdata_o (ram_wdata),
        .ram_rdata_i (ram_rdata)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .index_i (ram_index),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

`default_nettype wire

//--- verification/tb_mem_subsys.sv
`default_nettype none

module tb_mem_subsys import mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 5;
    localparam int SEED          = 32'h9997_0ca1;
    localparam int RANDOM_OPS    = 200;
    // stalled cycles of one access with the controller idle
    localparam int ACCESS_STALLS = 2;
    localparam int OP_LIMIT      = 16;
    // nop, word, merge, extend, window fill and random sections
    localparam int TOTAL_OPS     = 8 + 2 + 18 + 26 + 16 + RANDOM_OPS;
    // an access takes 3 cycles, 4 leaves slack
    localparam int WATCHDOG_NS   = (TOTAL_OPS * 4 + RESET_CYCLES + 20) * CLK_PERIOD;

    logic      clk;
    logic      rst;
    logic      wb_en_i;
    reg_addr_t wb_addr_i;
    word_t     alu_result_i;
    word_t     store_data_i;
    mem_op_t   mem_op_i;
    logic      wb_en_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;
    logic      stall_o;

    int errors;
    int checks;
    int tests_run;

    // outputs seen in the completing cycle of the last op
    logic      seen_wb_en;
    reg_addr_t seen_wb_addr;
    word_t     seen_wb_data;

    // byte model of the RAM, little-endian lanes
    logic [7:0] model_mem [RAM_DEPTH_WORDS*4];

    mem_subsys_top dut (
        .clk          (clk),
        .rst          (rst),
        .wb_en_i      (wb_en_i),
        .wb_addr_i    (wb_addr_i),
        .alu_result_i (alu_result_i),
        .store_data_i (store_data_i),
        .mem_op_i     (mem_op_i),
        .wb_en_o      (wb_en_o),
        .wb_addr_o    (wb_addr_o),
        .wb_data_o    (wb_data_o),
        .stall_o      (stall_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic mem_op_t encode_mem_op(input logic write, input mem_size_t size,
                                              input logic zero_ext);
        mem_op_t op;
        op = '0;
        op[MEM_OP_EN_BIT] = 1'b1;
        op[MEM_OP_SIZE_HI:MEM_OP_SIZE_LO] = size;
        op[MEM_OP_WRITE_BIT] = write;
        op[MEM_OP_UNSIGNED_BIT] = zero_ext;
        return op;
    endfunction

    function automatic int access_bytes(input mem_size_t size);
        if (size == SIZE_BYTE) begin
            return 1;
        end else if (size == SIZE_HALF) begin
            return 2;
        end
        return 4;
    endfunction

    // only address bits 9..0 reach the RAM
    function automatic logic [RAM_INDEX_W+1:0] byte_index(input word_t addr, input int k);
        return addr[RAM_INDEX_W+1:0] + (RAM_INDEX_W+2)'(k);
    endfunction

    // expected load result, sign bit is the top bit of the last byte read
    function automatic word_t model_load(input word_t addr, input mem_size_t size,
                                         input logic zero_ext);
        word_t raw;
        int    nbytes;
        raw = '0;
        nbytes = access_bytes(size);
        for (int k = 0; k < nbytes; k++) begin
            raw[8*k +: 8] = model_mem[byte_index(addr, k)];
        end
        if (!zero_ext && raw[8*nbytes-1]) begin
            raw = raw | (32'hFFFF_FFFF << (8 * nbytes));
        end
        return raw;
    endfunction

    task automatic model_store(input word_t addr, input mem_size_t size, input word_t data);
        for (int k = 0; k < access_bytes(size); k++) begin
            model_mem[byte_index(addr, k)] = data[8*k +: 8];
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_latency(input word_t addr, input int stalls);
        checks++;
        if (stalls != ACCESS_STALLS) begin
            errors++;
            $display("access to %h stalled %0d cycles instead of %0d", addr, stalls,
                     ACCESS_STALLS);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests_run++;
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    // present one instruction, wait for stall to drop, sample mid-cycle
    task automatic drive_op(input logic wb_en, input reg_addr_t wb_addr, input word_t alu,
                            input word_t sdata, input mem_op_t op, output int stalls);
        @(posedge clk);
        wb_en_i      <= wb_en;
        wb_addr_i    <= wb_addr;
        alu_result_i <= alu;
        store_data_i <= sdata;
        mem_op_i     <= op;
        stalls = 0;
        @(negedge clk);
        while (stall_o === 1'b1 && stalls < OP_LIMIT) begin
            stalls++;
            @(negedge clk);
        end
        if (stall_o !== 1'b0) begin
            errors++;
            $display("operation at %h never released the stall", alu);
        end
        seen_wb_en   = wb_en_o;
        seen_wb_addr = wb_addr_o;
        seen_wb_data = wb_data_o;
    endtask

    // stores write back the ALU result with the enable cleared
    task automatic store_mem(input word_t addr, input mem_size_t size, input word_t data);
        int stalls;
        drive_op(1'b0, 5'd0, addr, data, encode_mem_op(1'b1, size, 1'b0), stalls);
        check_latency(addr, stalls);
        check_word("wb_data_o", seen_wb_data, addr);
        check_bit("wb_en_o", seen_wb_en, 1'b0);
        model_store(addr, size, data);
    endtask

    task automatic load_mem(input word_t addr, input mem_size_t size, input logic zero_ext,
                            input reg_addr_t rd);
        int stalls;
        drive_op(1'b1, rd, addr, ~addr, encode_mem_op(1'b0, size, zero_ext), stalls);
        check_latency(addr, stalls);
        check_word("wb_data_o", seen_wb_data, model_load(addr, size, zero_ext));
        check_reg_addr("wb_addr_o", seen_wb_addr, rd);
        check_bit("wb_en_o", seen_wb_en, 1'b1);
    endtask

    // a load is held on the inputs through reset, outputs must stay low
    task automatic test_reset_state();
        int start;
        start = errors;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_bit("stall_o", stall_o, 1'b0);
        check_bit("wb_en_o", wb_en_o, 1'b0);
        @(posedge clk);
        rst      <= 1'b0;
        wb_en_i  <= 1'b0;
        mem_op_i <= '0;
        @(negedge clk);
        check_bit("stall_o", stall_o, 1'b0);
        check_bit("wb_en_o", wb_en_o, 1'b0);
        report_test("reset_state", start);
    endtask

    task automatic test_passthrough();
        int      start;
        int      stalls;
        word_t   r;
        word_t   alu;
        mem_op_t op;
        start = errors;
        for (int n = 0; n < 8; n++) begin
            r   = $urandom;
            alu = $urandom;
            // random op bits with the memory enable cleared
            op  = r[4:0];
            op[MEM_OP_EN_BIT] = 1'b0;
            drive_op(r[5], r[10:6], alu, $urandom, op, stalls);
            check_bit("stall_o", stalls != 0, 1'b0);
            check_word("wb_data_o", seen_wb_data, alu);
            check_reg_addr("wb_addr_o", seen_wb_addr, r[10:6]);
            check_bit("wb_en_o", seen_wb_en, r[5]);
        end
        report_test("passthrough", start);
    endtask

    task automatic test_word_roundtrip();
        int start;
        start = errors;
        store_mem(32'h0000_0100, SIZE_WORD, 32'hDEAD_BEEF);
        load_mem(32'h0000_0100, SIZE_WORD, 1'b0, 5'd1);
        report_test("word_roundtrip", start);
    endtask

    // sub-word store into a known word, read back whole
    task automatic test_subword_merge();
        int start;
        start = errors;
        for (int off = 0; off < 4; off++) begin
            store_mem(32'h0000_0200, SIZE_WORD, 32'h1122_3344);
            store_mem(32'h0000_0200 + word_t'(off), SIZE_BYTE, 32'h5566_77A0 + word_t'(off));
            load_mem(32'h0000_0200, SIZE_WORD, 1'b0, 5'd2);
        end
        for (int off = 0; off < 4; off += 2) begin
            store_mem(32'h0000_0200, SIZE_WORD, 32'h1122_3344);
            store_mem(32'h0000_0200 + word_t'(off), SIZE_HALF, 32'h9988_C0DE + word_t'(off));
            load_mem(32'h0000_0200, SIZE_WORD, 1'b0, 5'd2);
        end
        report_test("subword_merge", start);
    endtask

    task automatic test_load_extend();
        int    start;
        word_t base;
        word_t pattern [2];
        start = errors;
        // every byte and halfword of the first pattern has its top bit set
        pattern[0] = 32'h80FF_9281;
        pattern[1] = 32'h7F30_6A15;
        for (int p = 0; p < 2; p++) begin
            base = 32'h0000_0300 + word_t'(4 * p);
            store_mem(base, SIZE_WORD, pattern[p]);
            for (int off = 0; off < 4; off++) begin
                load_mem(base + word_t'(off), SIZE_BYTE, 1'b0, 5'd3);
                load_mem(base + word_t'(off), SIZE_BYTE, 1'b1, 5'd4);
            end
            for (int off = 0; off < 4; off += 2) begin
                load_mem(base + word_t'(off), SIZE_HALF, 1'b0, 5'd5);
                load_mem(base + word_t'(off), SIZE_HALF, 1'b1, 5'd6);
            end
        end
        report_test("load_extend", start);
    endtask

    task automatic test_random_traffic();
        int        start;
        word_t     r;
        word_t     addr;
        mem_size_t size;
        start = errors;
        // fill the 16 word window at 0x100 so no load reads unwritten bytes
        for (int w = 0; w < 16; w++) begin
            addr = 32'h0000_0100 + word_t'(4 * w);
            store_mem(addr, SIZE_WORD, addr * 32'h9E37_79B1);
        end
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = $urandom;
            case (r[1:0])
                2'd0:    size = SIZE_BYTE;
                2'd1:    size = SIZE_HALF;
                default: size = SIZE_WORD;
            endcase
            // upper bits random, they alias back onto the window
            addr = $urandom;
            addr[9:6] = 4'b0100;
            if (size == SIZE_HALF) begin
                addr[0] = 1'b0;
            end else if (size == SIZE_WORD) begin
                addr[1:0] = 2'b00;
            end
            if (r[2]) begin
                store_mem(addr, size, $urandom);
            end else begin
                load_mem(addr, size, r[3], r[8:4]);
            end
        end
        report_test("random_traffic", start);
    endtask

    initial begin
        void'($urandom(SEED));
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        rst          = 1'b1;
        wb_en_i      = 1'b1;
        wb_addr_i    = 5'd7;
        alu_result_i = '0;
        store_data_i = '0;
        mem_op_i     = encode_mem_op(1'b0, SIZE_WORD, 1'b0);
        test_reset_state();
        test_passthrough();
        test_word_roundtrip();
        test_subword_merge();
        test_load_extend();
        test_random_traffic();
        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_stage.f
common/mem_pkg.sv
mem_access/mem_access.sv
mem_ctrl/data_ram.sv
mem_ctrl/mem_ctrl.sv
rtl/mem_subsys_top.sv
verification/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mem_subsys \
    -f mem_stage.f -Mdir obj_dir -o sim_mem_subsys \
    || { echo "verilator build failed"; exit 1; }

output=$(./obj_dir/sim_mem_subsys)
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -qx "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
